// ==== design/chase_pkg.sv ====
`default_nettype none

package chase_pkg;

    localparam int POS_W    = 10;
    localparam int LLR_W    = 7;
    localparam int SUM_W    = 10;
    localparam int MAX_ERR  = 2;
    localparam int NUM_FLIP = 2;
    localparam int NUM_TP   = 4;
    localparam int CAND_LEN = 4;
    localparam int MEM_LAT  = 2;

    typedef logic [POS_W-1:0]          pos_t;
    typedef logic [LLR_W-1:0]          llr_t;
    typedef logic [SUM_W-1:0]          sum_t;
    typedef logic [$clog2(NUM_TP)-1:0] tp_idx_t;
    // 0 = no slot, 1..4 name a stored candidate
    typedef logic [2:0]                slot_t;

    // empty entry, sorts behind every real position
    localparam pos_t POS_NONE = '1;

    // one hard-decoder result
    typedef struct packed {
        pos_t [MAX_ERR-1:0] loc;
        logic [2:0]         num_err;
        logic               correct;
    } tp_in_t;

    typedef struct packed {
        pos_t [NUM_FLIP-1:0] pos;
    } flip_pair_t;

    typedef struct packed {
        pos_t [MAX_ERR-1:0] addr;
    } addr_pair_t;

    typedef struct packed {
        llr_t [MAX_ERR-1:0] data;
    } llr_pair_t;

    // pos[0] holds the smallest position
    typedef struct packed {
        pos_t [CAND_LEN-1:0] pos;
        logic [2:0]          count;
    } cand_t;

    typedef cand_t [NUM_TP-1:0] cand_bank_t;

endpackage

`default_nettype wire

// ==== design/candidate_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module candidate_merge (
    input  chase_pkg::tp_in_t     i_tp,
    input  chase_pkg::flip_pair_t i_flip,
    input  chase_pkg::tp_idx_t    i_tp_idx,
    output chase_pkg::cand_t      o_cand
);

    chase_pkg::pos_t [chase_pkg::CAND_LEN-1:0] merged;
    chase_pkg::pos_t [chase_pkg::CAND_LEN-1:0] st1;
    chase_pkg::pos_t [chase_pkg::CAND_LEN-1:0] st2;
    chase_pkg::pos_t [chase_pkg::CAND_LEN-1:0] st3;

    // returns {smaller, larger}
    function automatic logic [2*chase_pkg::POS_W-1:0] order2(
        input chase_pkg::pos_t a,
        input chase_pkg::pos_t b
    );
        return (a > b) ? {b, a} : {a, b};
    endfunction

    // error locations first, then the flips of this pattern
    always_comb begin
        for (int i = 0; i < chase_pkg::MAX_ERR; i++) begin
            if (i_tp.num_err > i) begin
                merged[i] = i_tp.loc[i];
            end else begin
                merged[i] = chase_pkg::POS_NONE;
            end
        end
        for (int j = 0; j < chase_pkg::NUM_FLIP; j++) begin
            if (i_tp_idx[j]) begin
                merged[chase_pkg::MAX_ERR + j] = i_flip.pos[j];
            end else begin
                merged[chase_pkg::MAX_ERR + j] = chase_pkg::POS_NONE;
            end
        end
    end

    // five compare-exchange sorting network
    always_comb begin
        {st1[0], st1[1]} = order2(merged[0], merged[1]);
        {st1[2], st1[3]} = order2(merged[2], merged[3]);
        {st2[0], st2[2]} = order2(st1[0], st1[2]);
        {st2[1], st2[3]} = order2(st1[1], st1[3]);
        st3[0] = st2[0];
        st3[3] = st2[3];
        {st3[1], st3[2]} = order2(st2[1], st2[2]);
    end

    always_comb begin
        o_cand.pos   = st3;
        o_cand.count = i_tp.num_err + 3'(i_tp_idx[0]) + 3'(i_tp_idx[1]);
    end

endmodule

`default_nettype wire

// ==== design/candidate_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module candidate_bank (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_clear,
    input  logic                  i_tp_valid,
    input  logic                  i_correct,
    input  chase_pkg::cand_t      i_cand,
    output chase_pkg::tp_idx_t    o_tp_idx,
    output chase_pkg::slot_t      o_next_slot,
    output chase_pkg::cand_bank_t o_cand,
    output chase_pkg::slot_t      o_num_saved
);

    logic room_left;

    assign room_left = o_num_saved < 3'(chase_pkg::NUM_TP);

    // slot number a correct pattern arriving now would receive
    assign o_next_slot = o_num_saved + 3'd1;

    // pattern number advances on every pulse
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            o_tp_idx <= '0;
        end else if (i_tp_valid) begin
            o_tp_idx <= o_tp_idx + 1'b1;
        end
    end

    // correct patterns fill slots in arrival order
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            o_num_saved <= '0;
        end else if (i_tp_valid && i_correct && room_left) begin
            o_num_saved <= o_num_saved + 3'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            for (int s = 0; s < chase_pkg::NUM_TP; s++) begin
                o_cand[s].pos   <= {chase_pkg::CAND_LEN{chase_pkg::POS_NONE}};
                o_cand[s].count <= '0;
            end
        end else if (i_tp_valid && i_correct && room_left) begin
            o_cand[o_num_saved[1:0]] <= i_cand;
        end
    end

endmodule

`default_nettype wire

// ==== design/llr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module llr_fetch (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_clear,
    input  logic                  i_flip_valid,
    input  chase_pkg::flip_pair_t i_flip,
    input  logic                  i_tp_valid,
    input  chase_pkg::tp_in_t     i_tp,
    input  chase_pkg::tp_idx_t    i_tp_idx,
    input  chase_pkg::slot_t      i_slot,
    input  chase_pkg::llr_pair_t  i_llr_mem_data,
    output chase_pkg::addr_pair_t o_llr_mem_addr,
    output logic                  o_metric_valid,
    output logic                  o_metric_correct,
    output chase_pkg::slot_t      o_metric_slot,
    output chase_pkg::sum_t       o_metric_sum
);

    // what a read in flight belongs to
    typedef struct packed {
        logic                valid;
        logic                flip;
        logic                correct;
        chase_pkg::slot_t    slot;
        chase_pkg::tp_idx_t  tp_idx;
        logic [2:0]          num_err;
    } tag_t;

    logic flip_valid_q;
    logic flip_rise;
    tag_t tag_in;
    tag_t tag_out;
    tag_t [chase_pkg::MEM_LAT-1:0] tag_q;
    chase_pkg::llr_t [chase_pkg::NUM_FLIP-1:0] flip_llr;

    assign flip_rise = i_flip_valid && !flip_valid_q;

    // the flip read never meets a pattern pulse
    assign o_llr_mem_addr.addr = flip_rise ? i_flip.pos : i_tp.loc;

    always_comb begin
        tag_in.valid   = i_tp_valid;
        tag_in.flip    = flip_rise;
        tag_in.correct = i_tp.correct;
        tag_in.slot    = i_slot;
        tag_in.tp_idx  = i_tp_idx;
        tag_in.num_err = i_tp.num_err;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            flip_valid_q <= 1'b0;
        end else begin
            flip_valid_q <= i_flip_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            tag_q <= '0;
        end else begin
            tag_q[0] <= tag_in;
            for (int k = 1; k < chase_pkg::MEM_LAT; k++) begin
                tag_q[k] <= tag_q[k-1];
            end
        end
    end

    assign tag_out = tag_q[chase_pkg::MEM_LAT-1];

    // weak-position reliabilities stay for the whole codeword
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            flip_llr <= '0;
        end else if (tag_out.flip) begin
            flip_llr <= i_llr_mem_data.data;
        end
    end

    always_comb begin
        o_metric_sum = '0;
        for (int i = 0; i < chase_pkg::MAX_ERR; i++) begin
            if (tag_out.num_err > i) begin
                o_metric_sum = o_metric_sum + chase_pkg::sum_t'(i_llr_mem_data.data[i]);
            end
        end
        for (int j = 0; j < chase_pkg::NUM_FLIP; j++) begin
            if (tag_out.tp_idx[j]) begin
                o_metric_sum = o_metric_sum + chase_pkg::sum_t'(flip_llr[j]);
            end
        end
    end

    assign o_metric_valid   = tag_out.valid;
    assign o_metric_correct = tag_out.correct;
    assign o_metric_slot    = tag_out.slot;

endmodule

`default_nettype wire

// ==== design/best_pattern_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module best_pattern_select (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_clear,
    input  logic             i_metric_valid,
    input  logic             i_metric_correct,
    input  chase_pkg::slot_t i_metric_slot,
    input  chase_pkg::sum_t  i_metric_sum,
    output chase_pkg::slot_t o_best_slot,
    output logic             o_done
);

    chase_pkg::sum_t min_sum;
    logic [2:0]      metric_cnt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            min_sum     <= '1;
            o_best_slot <= '0;
        end else if (i_metric_valid && i_metric_correct && (i_metric_sum < min_sum)) begin
            // strict compare, a tie keeps the earlier slot
            min_sum     <= i_metric_sum;
            o_best_slot <= i_metric_slot;
        end
    end

    // uncorrectable patterns count toward completion too
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            metric_cnt <= '0;
            o_done     <= 1'b0;
        end else begin
            if (i_metric_valid) begin
                metric_cnt <= metric_cnt + 3'd1;
            end
            if (metric_cnt == 3'(chase_pkg::NUM_TP)) begin
                o_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/chase_tp_saver.sv ====
`timescale 1ns/1ps
`default_nettype none

module chase_tp_saver (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_clear,
    input  logic                  i_tp_valid,
    input  chase_pkg::tp_in_t     i_tp,
    input  logic                  i_flip_valid,
    input  chase_pkg::flip_pair_t i_flip,
    output chase_pkg::addr_pair_t o_llr_mem_addr,
    input  chase_pkg::llr_pair_t  i_llr_mem_data,
    output chase_pkg::cand_bank_t o_cand,
    output chase_pkg::slot_t      o_num_saved,
    output chase_pkg::slot_t      o_best_slot,
    output logic                  o_done
);

    chase_pkg::tp_idx_t tp_idx;
    chase_pkg::slot_t   next_slot;
    chase_pkg::cand_t   merged_cand;
    logic               metric_valid;
    logic               metric_correct;
    chase_pkg::slot_t   metric_slot;
    chase_pkg::sum_t    metric_sum;

    candidate_merge candidate_merge_inst (
        .i_tp     (i_tp),
        .i_flip   (i_flip),
        .i_tp_idx (tp_idx),
        .o_cand   (merged_cand)
    );

    candidate_bank candidate_bank_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (i_clear),
        .i_tp_valid  (i_tp_valid),
        .i_correct   (i_tp.correct),
        .i_cand      (merged_cand),
        .o_tp_idx    (tp_idx),
        .o_next_slot (next_slot),
        .o_cand      (o_cand),
        .o_num_saved (o_num_saved)
    );

    llr_fetch llr_fetch_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_clear          (i_clear),
        .i_flip_valid     (i_flip_valid),
        .i_flip           (i_flip),
        .i_tp_valid       (i_tp_valid),
        .i_tp             (i_tp),
        .i_tp_idx         (tp_idx),
        .i_slot           (next_slot),
        .i_llr_mem_data   (i_llr_mem_data),
        .o_llr_mem_addr   (o_llr_mem_addr),
        .o_metric_valid   (metric_valid),
        .o_metric_correct (metric_correct),
        .o_metric_slot    (metric_slot),
        .o_metric_sum     (metric_sum)
    );

    best_pattern_select best_pattern_select_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_clear          (i_clear),
        .i_metric_valid   (metric_valid),
        .i_metric_correct (metric_correct),
        .i_metric_slot    (metric_slot),
        .i_metric_sum     (metric_sum),
        .o_best_slot      (o_best_slot),
        .o_done           (o_done)
    );

endmodule

`default_nettype wire

// ==== tb/chase_tp_saver_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module chase_tp_saver_properties (
    input logic             i_clk,
    input logic             i_rst_n,
    input logic             i_clear,
    input logic             i_tp_valid,
    input chase_pkg::slot_t i_num_saved,
    input chase_pkg::slot_t i_best_slot,
    input logic             i_done
);

    int   done_fails  = 0;
    int   slot_fails  = 0;
    int   saved_fails = 0;
    int   fail_count;
    logic tp_seen;

    assign fail_count = done_fails + slot_fails + saved_fails;

    // any pattern pulse since the last clear
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            tp_seen <= 1'b0;
        end else if (i_tp_valid) begin
            tp_seen <= 1'b1;
        end
    end

    done_needs_pattern: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_done && (i_num_saved == 3'd0) && !tp_seen))
    else begin
        done_fails = done_fails + 1;
        $error("done is high although no pattern was sent since clear");
    end

    best_within_saved: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_best_slot <= i_num_saved)
    else begin
        slot_fails = slot_fails + 1;
        $error("best slot %0d is beyond saved count %0d", i_best_slot, i_num_saved);
    end

    saved_monotonic: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_num_saved < $past(i_num_saved)) |-> ($past(i_clear) || !$past(i_rst_n)))
    else begin
        saved_fails = saved_fails + 1;
        $error("saved count decreased without a clear");
    end

endmodule

bind chase_tp_saver chase_tp_saver_properties chase_tp_saver_properties_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_tp_valid  (i_tp_valid),
    .i_num_saved (o_num_saved),
    .i_best_slot (o_best_slot),
    .i_done      (o_done)
);

`default_nettype wire

// ==== tb/tb_chase_tp_saver.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_chase_tp_saver;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 10;
    localparam int NUM_TESTS  = 5;
    localparam int DONE_LIMIT = 20;
    localparam int MEM_DEPTH  = 1024;

    typedef logic [191:0] word_t;

    logic                  clk;
    logic                  rst_n;
    logic                  clear;
    logic                  tp_valid;
    chase_pkg::tp_in_t     tp;
    logic                  flip_valid;
    chase_pkg::flip_pair_t flip;
    chase_pkg::addr_pair_t llr_mem_addr;
    chase_pkg::llr_pair_t  llr_mem_data;
    chase_pkg::cand_bank_t cand;
    chase_pkg::slot_t      num_saved;
    chase_pkg::slot_t      best_slot;
    logic                  done;

    chase_pkg::llr_t      llr_mem [MEM_DEPTH];
    chase_pkg::llr_pair_t rd_stage1 = '0;
    chase_pkg::llr_pair_t rd_stage2 = '0;
    chase_pkg::tp_in_t    pat [chase_pkg::NUM_TP];
    logic [31:0]          lcg_state;

    chase_tp_saver chase_tp_saver_inst (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_clear        (clear),
        .i_tp_valid     (tp_valid),
        .i_tp           (tp),
        .i_flip_valid   (flip_valid),
        .i_flip         (flip),
        .o_llr_mem_addr (llr_mem_addr),
        .i_llr_mem_data (llr_mem_data),
        .o_cand         (cand),
        .o_num_saved    (num_saved),
        .o_best_slot    (best_slot),
        .o_done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // two-cycle read latency LLR memory
    always @(posedge clk) begin
        for (int k = 0; k < chase_pkg::MAX_ERR; k++) begin
            rd_stage1.data[k] <= llr_mem[llr_mem_addr.addr[k]];
        end
        rd_stage2 <= rd_stage1;
    end

    assign llr_mem_data = rd_stage2;

    initial begin
        #((RST_CYCLES + NUM_TESTS * 200) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string test_name, input string what,
                               input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("mismatch in %s (%s): expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    function automatic chase_pkg::tp_in_t make_tp(input logic ok, input int n,
                                                  input int l0, input int l1);
        chase_pkg::tp_in_t t;
        t.correct = ok;
        t.num_err = 3'(n);
        t.loc[0]  = chase_pkg::pos_t'(l0);
        t.loc[1]  = chase_pkg::pos_t'(l1);
        return t;
    endfunction

    function automatic chase_pkg::flip_pair_t make_flip(input int p1, input int p2);
        chase_pkg::flip_pair_t f;
        f.pos[0] = chase_pkg::pos_t'(p1);
        f.pos[1] = chase_pkg::pos_t'(p2);
        return f;
    endfunction

    function automatic chase_pkg::cand_bank_t empty_bank();
        chase_pkg::cand_bank_t b;
        for (int s = 0; s < chase_pkg::NUM_TP; s++) begin
            b[s].pos   = {chase_pkg::CAND_LEN{chase_pkg::POS_NONE}};
            b[s].count = 3'd0;
        end
        return b;
    endfunction

    // counted locations plus pattern flips sorted ascending and padded
    function automatic chase_pkg::cand_t model_cand(input chase_pkg::tp_in_t t,
                                                    input chase_pkg::flip_pair_t f,
                                                    input int idx);
        chase_pkg::pos_t v [chase_pkg::CAND_LEN];
        chase_pkg::pos_t tmp;
        chase_pkg::cand_t c;
        int n;
        int nflip;
        n = 0;
        nflip = 0;
        for (int k = 0; k < chase_pkg::CAND_LEN; k++) begin
            v[k] = chase_pkg::POS_NONE;
        end
        for (int k = 0; k < chase_pkg::MAX_ERR; k++) begin
            if (int'(t.num_err) > k) begin
                v[n] = t.loc[k];
                n++;
            end
        end
        for (int j = 0; j < chase_pkg::NUM_FLIP; j++) begin
            if (((idx >> j) & 1) == 1) begin
                v[n] = f.pos[j];
                n++;
                nflip++;
            end
        end
        for (int a = 0; a < chase_pkg::CAND_LEN - 1; a++) begin
            for (int b = 0; b < chase_pkg::CAND_LEN - 1 - a; b++) begin
                if (v[b] > v[b+1]) begin
                    tmp    = v[b];
                    v[b]   = v[b+1];
                    v[b+1] = tmp;
                end
            end
        end
        for (int k = 0; k < chase_pkg::CAND_LEN; k++) begin
            c.pos[k] = v[k];
        end
        c.count = t.num_err + 3'(nflip);
        return c;
    endfunction

    function automatic int model_sum(input chase_pkg::tp_in_t t,
                                     input chase_pkg::flip_pair_t f, input int idx);
        int s;
        s = 0;
        for (int k = 0; k < chase_pkg::MAX_ERR; k++) begin
            if (int'(t.num_err) > k) begin
                s += int'(llr_mem[t.loc[k]]);
            end
        end
        for (int j = 0; j < chase_pkg::NUM_FLIP; j++) begin
            if (((idx >> j) & 1) == 1) begin
                s += int'(llr_mem[f.pos[j]]);
            end
        end
        return s;
    endfunction

    task automatic clear_pulse();
        clear      = 1'b1;
        flip_valid = 1'b0;
        tp_valid   = 1'b0;
        next_cycle();
        clear = 1'b0;
    endtask

    task automatic check_idle(input string test_name);
        check_value(test_name, "done", word_t'(1'b0), word_t'(done));
        check_value(test_name, "best_slot", word_t'(3'd0), word_t'(best_slot));
        check_value(test_name, "num_saved", word_t'(3'd0), word_t'(num_saved));
        check_value(test_name, "candidates", word_t'(empty_bank()), word_t'(cand));
    endtask

    // one codeword from the patterns in pat with gap idle cycles between pulses
    task automatic run_codeword(input string test_name, input chase_pkg::flip_pair_t f,
                                input int gap);
        chase_pkg::cand_bank_t exp_bank;
        chase_pkg::slot_t exp_saved;
        chase_pkg::slot_t exp_best;
        int best_sum;
        int s;
        int waited;
        exp_bank  = empty_bank();
        exp_saved = 3'd0;
        exp_best  = 3'd0;
        best_sum  = 1 << chase_pkg::SUM_W;
        for (int i = 0; i < chase_pkg::NUM_TP; i++) begin
            if (pat[i].correct) begin
                exp_bank[exp_saved[1:0]] = model_cand(pat[i], f, i);
                exp_saved = exp_saved + 3'd1;
                s = model_sum(pat[i], f, i);
                if (s < best_sum) begin
                    best_sum = s;
                    exp_best = exp_saved;
                end
            end
        end
        clear_pulse();
        flip       = f;
        flip_valid = 1'b1;
        #1;
        check_value(test_name, "flip read address", word_t'(f), word_t'(llr_mem_addr));
        repeat (3) next_cycle();
        for (int i = 0; i < chase_pkg::NUM_TP; i++) begin
            tp       = pat[i];
            tp_valid = 1'b1;
            #1;
            check_value(test_name, "pattern read address", word_t'(pat[i].loc),
                        word_t'(llr_mem_addr));
            next_cycle();
            tp_valid = 1'b0;
            if (i < chase_pkg::NUM_TP - 1) begin
                repeat (gap) next_cycle();
            end
        end
        check_value(test_name, "num_saved", word_t'(exp_saved), word_t'(num_saved));
        check_value(test_name, "candidates", word_t'(exp_bank), word_t'(cand));
        repeat (2) next_cycle();
        check_value(test_name, "best_slot", word_t'(exp_best), word_t'(best_slot));
        waited = 0;
        while (!done && waited < DONE_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!done) begin
            $display("%s: done never rose after the fourth pattern", test_name);
            $display("*** TEST FAILED ***");
            $fatal(1, "done timeout");
        end
        check_value(test_name, "done latency", word_t'(4), word_t'(3 + waited));
    endtask

    task automatic test_merge_sort();
        pat[0] = make_tp(1'b1, 0, 100, 200);
        pat[1] = make_tp(1'b1, 1, 700, 3);
        pat[2] = make_tp(1'b1, 2, 900, 5);
        pat[3] = make_tp(1'b1, 2, 1000, 250);
        run_codeword("merge_sort", make_flip(500, 20), 2);
    endtask

    task automatic test_slot_compaction();
        pat[0] = make_tp(1'b0, 2, 40, 60);
        pat[1] = make_tp(1'b1, 1, 300, 0);
        pat[2] = make_tp(1'b0, 1, 77, 0);
        pat[3] = make_tp(1'b1, 2, 15, 800);
        run_codeword("slot_compaction", make_flip(123, 456), 1);
    endtask

    task automatic test_min_select();
        logic [31:0] r;
        chase_pkg::flip_pair_t f;
        int partner;
        for (int i = 0; i < chase_pkg::NUM_TP; i++) begin
            r = next_random();
            pat[i] = make_tp(1'b1, int'(r % 32'd3), int'(next_random() >> 22),
                             int'(next_random() >> 22));
        end
        pat[0].correct = r[3];
        r = next_random();
        run_codeword("min_select_random", make_flip(int'(r[25:16]), int'(r[9:0])), 0);

        // second flip with the same reliability as the first forces a tie
        r = next_random();
        f.pos[0] = r[25:16];
        partner = -1;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            if (partner < 0 && a != int'(f.pos[0]) && llr_mem[a] == llr_mem[f.pos[0]]) begin
                partner = a;
            end
        end
        if (partner < 0) begin
            $display("no second position with an equal reliability exists in the LLR memory");
            $display("*** TEST FAILED ***");
            $fatal(1, "tie setup failed");
        end
        f.pos[1] = chase_pkg::pos_t'(partner);
        pat[0] = make_tp(1'b0, 2, 11, 12);
        pat[1] = make_tp(1'b1, 0, 0, 0);
        pat[2] = make_tp(1'b1, 0, 0, 0);
        pat[3] = make_tp(1'b1, 0, 0, 0);
        run_codeword("min_select_tie", f, 0);
    endtask

    task automatic test_no_correct();
        logic [31:0] r;
        for (int i = 0; i < chase_pkg::NUM_TP; i++) begin
            r = next_random();
            pat[i] = make_tp(1'b0, int'(r % 32'd3), int'(r[25:16]), int'(r[9:0]));
        end
        run_codeword("no_correct", make_flip(64, 640), 1);
    endtask

    task automatic test_clear();
        pat[0] = make_tp(1'b1, 2, 33, 66);
        pat[1] = make_tp(1'b1, 0, 0, 0);
        pat[2] = make_tp(1'b1, 1, 999, 0);
        pat[3] = make_tp(1'b0, 1, 1, 0);
        run_codeword("clear_first", make_flip(210, 420), 0);
        clear_pulse();
        check_idle("clear_idle");
        pat[0] = make_tp(1'b0, 0, 0, 0);
        pat[1] = make_tp(1'b1, 2, 512, 8);
        pat[2] = make_tp(1'b1, 1, 95, 0);
        pat[3] = make_tp(1'b1, 1, 95, 0);
        run_codeword("clear_second", make_flip(7, 1022), 2);
    endtask

    initial begin
        rst_n      = 1'b0;
        clear      = 1'b0;
        tp_valid   = 1'b0;
        tp         = '0;
        flip_valid = 1'b0;
        flip       = '0;
        lcg_state  = 32'hdb3d;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            llr_mem[a] = chase_pkg::llr_t'(next_random() >> 16) ^ chase_pkg::llr_t'(a)
                         ^ chase_pkg::llr_t'(a >> 7);
        end
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        test_merge_sort();
        test_slot_compaction();
        test_min_select();
        test_no_correct();
        test_clear();

        next_cycle();
        if (chase_tp_saver_inst.chase_tp_saver_properties_inst.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d assertion failures were reported",
                     chase_tp_saver_inst.chase_tp_saver_properties_inst.fail_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== chase_tp_saver.f ====
design/chase_pkg.sv
design/candidate_merge.sv
design/candidate_bank.sv
design/llr_fetch.sv
design/best_pattern_select.sv
design/chase_tp_saver.sv
tb/chase_tp_saver_properties.sv
tb/tb_chase_tp_saver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the chase_tp_saver testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_chase_tp_saver -Mdir obj_dir -f chase_tp_saver.f; then
    echo "verilator build failed"
    exit 1
fi

obj_dir/Vtb_chase_tp_saver +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
